// ==== verilog/matrix_cfg.svh ====
`ifndef MATRIX_CFG_SVH
`define MATRIX_CFG_SVH

// panel geometry
`define MATRIX_WIDTH 64
`define MATRIX_HEIGHT 32
`define BYTES_PER_PIXEL 2

// one enable per bit plane
`define BRIGHTNESS_LEVELS 6

// serial bit period in clk_in cycles
`define UART_CLKS_PER_BIT 16

`endif

// ==== verilog/matrix_cmd_pkg.sv ====
`default_nettype none

package matrix_cmd_pkg;

    // command bytes, ascii encoded
    typedef enum logic [7:0] {
        CMD_RED_ON        = 8'h52,
        CMD_RED_OFF       = 8'h72,
        CMD_GREEN_ON      = 8'h47,
        CMD_GREEN_OFF     = 8'h67,
        CMD_BLUE_ON       = 8'h42,
        CMD_BLUE_OFF      = 8'h62,
        CMD_BRIGHT_1      = 8'h31,
        CMD_BRIGHT_2      = 8'h32,
        CMD_BRIGHT_3      = 8'h33,
        CMD_BRIGHT_4      = 8'h34,
        CMD_BRIGHT_5      = 8'h35,
        CMD_BRIGHT_6      = 8'h36,
        CMD_BRIGHT_NONE   = 8'h30,
        CMD_BRIGHT_ALL    = 8'h39,
        CMD_LINE          = 8'h4c
    } cmd_opcode_e;

    typedef enum logic [1:0] {
        IDLE,
        ROW_WAIT,
        ROW_DATA
    } decode_state_e;

endpackage

`default_nettype wire

// ==== verilog/matrix_mem_pkg.sv ====
`default_nettype none

`include "matrix_cfg.svh"

package matrix_mem_pkg;

    // byte address splits into row and byte within the row
    parameter int ROW_BITS  = $clog2(`MATRIX_HEIGHT);
    parameter int COL_BITS  = $clog2(`MATRIX_WIDTH * `BYTES_PER_PIXEL);
    parameter int ADDR_BITS = ROW_BITS + COL_BITS;
    parameter int DATA_BITS = 8;
    parameter int FB_DEPTH  = 1 << ADDR_BITS;

    typedef logic [ADDR_BITS-1:0] fb_addr_t;
    typedef logic [DATA_BITS-1:0] fb_data_t;

    typedef struct packed {
        logic     valid;
        fb_addr_t addr;
        fb_data_t data;
    } fb_write_t;

endpackage

`default_nettype wire

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matrix_cfg.svh"

module uart_rx (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       uart_rx_line,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);
    localparam int CLKS     = `UART_CLKS_PER_BIT;
    localparam int CNT_BITS = $clog2(CLKS);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e           state;
    logic                rx_meta;
    logic                rx_sync;
    logic [CNT_BITS-1:0] bit_cnt;
    logic [2:0]          bit_idx;
    logic [7:0]          shift_reg;

    // line idles high
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= uart_rx_line;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state    <= RX_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            bit_cnt  <= bit_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                // half a bit in, confirm start is still low
                RX_START: begin
                    if (bit_cnt == CNT_BITS'(CLKS / 2 - 1)) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_cnt == CNT_BITS'(CLKS - 1)) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_cnt == CNT_BITS'(CLKS - 1)) begin
                        // framing error drops the byte
                        rx_valid <= rx_sync;
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk_in) begin
        if (state == RX_DATA && bit_cnt == CNT_BITS'(CLKS - 1)) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    assign rx_byte = shift_reg;

endmodule

`default_nettype wire

// ==== verilog/command_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matrix_cfg.svh"

module command_decoder (
    input  logic                          clk_in,
    input  logic                          reset,
    input  logic [7:0]                    rx_byte,
    input  logic                          rx_valid,
    output logic [2:0]                    rgb_enable,
    output logic [`BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output matrix_mem_pkg::fb_write_t     wr_req
);
    localparam int LEVELS = `BRIGHTNESS_LEVELS;

    matrix_cmd_pkg::decode_state_e         state;
    matrix_cmd_pkg::cmd_opcode_e           opcode;
    logic [matrix_mem_pkg::ROW_BITS-1:0]   line_row;
    logic [matrix_mem_pkg::COL_BITS-1:0]   line_col;
    logic                                  row_accept;
    logic                                  data_accept;
    logic                                  wr_valid;
    matrix_mem_pkg::fb_addr_t              wr_addr;
    matrix_mem_pkg::fb_data_t              wr_data;

    assign opcode = matrix_cmd_pkg::cmd_opcode_e'(rx_byte);

    // an "L" in the row slot is not a row number
    assign row_accept = rx_valid && state == matrix_cmd_pkg::ROW_WAIT &&
                        opcode != matrix_cmd_pkg::CMD_LINE;
    assign data_accept = rx_valid && state == matrix_cmd_pkg::ROW_DATA;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state             <= matrix_cmd_pkg::IDLE;
            rgb_enable        <= 3'b111;
            brightness_enable <= '1;
            line_col          <= '0;
            wr_valid          <= 1'b0;
        end else begin
            wr_valid <= 1'b0;
            if (rx_valid) begin
                case (state)
                    matrix_cmd_pkg::IDLE: begin
                        case (opcode)
                            matrix_cmd_pkg::CMD_RED_ON:    rgb_enable[0] <= 1'b1;
                            matrix_cmd_pkg::CMD_RED_OFF:   rgb_enable[0] <= 1'b0;
                            matrix_cmd_pkg::CMD_GREEN_ON:  rgb_enable[1] <= 1'b1;
                            matrix_cmd_pkg::CMD_GREEN_OFF: rgb_enable[1] <= 1'b0;
                            matrix_cmd_pkg::CMD_BLUE_ON:   rgb_enable[2] <= 1'b1;
                            matrix_cmd_pkg::CMD_BLUE_OFF:  rgb_enable[2] <= 1'b0;
                            // digit n flips plane LEVELS - n
                            matrix_cmd_pkg::CMD_BRIGHT_1: begin
                                brightness_enable[LEVELS-1] <= ~brightness_enable[LEVELS-1];
                            end
                            matrix_cmd_pkg::CMD_BRIGHT_2: begin
                                brightness_enable[LEVELS-2] <= ~brightness_enable[LEVELS-2];
                            end
                            matrix_cmd_pkg::CMD_BRIGHT_3: begin
                                brightness_enable[LEVELS-3] <= ~brightness_enable[LEVELS-3];
                            end
                            matrix_cmd_pkg::CMD_BRIGHT_4: begin
                                brightness_enable[LEVELS-4] <= ~brightness_enable[LEVELS-4];
                            end
                            matrix_cmd_pkg::CMD_BRIGHT_5: begin
                                brightness_enable[LEVELS-5] <= ~brightness_enable[LEVELS-5];
                            end
                            matrix_cmd_pkg::CMD_BRIGHT_6: begin
                                brightness_enable[LEVELS-6] <= ~brightness_enable[LEVELS-6];
                            end
                            matrix_cmd_pkg::CMD_BRIGHT_NONE: brightness_enable <= '0;
                            matrix_cmd_pkg::CMD_BRIGHT_ALL:  brightness_enable <= '1;
                            matrix_cmd_pkg::CMD_LINE:        state <= matrix_cmd_pkg::ROW_WAIT;
                            default: begin
                            end
                        endcase
                    end
                    matrix_cmd_pkg::ROW_WAIT: begin
                        if (row_accept) begin
                            line_col <= '0;
                            state    <= matrix_cmd_pkg::ROW_DATA;
                        end
                    end
                    matrix_cmd_pkg::ROW_DATA: begin
                        wr_valid <= 1'b1;
                        line_col <= line_col + 1'b1;
                        // counter wraps after the last byte of the row
                        if (line_col == '1) begin
                            state <= matrix_cmd_pkg::IDLE;
                        end
                    end
                    default: state <= matrix_cmd_pkg::IDLE;
                endcase
            end
        end
    end

    // row latch and write payload
    always_ff @(posedge clk_in) begin
        if (row_accept) begin
            line_row <= rx_byte[matrix_mem_pkg::ROW_BITS-1:0];
        end
        if (data_accept) begin
            wr_addr <= {line_row, line_col};
            wr_data <= rx_byte;
        end
    end

    assign wr_req = '{valid: wr_valid, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

// ==== verilog/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
    input  logic                      clk_in,
    input  matrix_mem_pkg::fb_write_t wr_req,
    input  matrix_mem_pkg::fb_addr_t  rd_addr,
    output matrix_mem_pkg::fb_data_t  rd_data
);
    // one byte per location, row major
    matrix_mem_pkg::fb_data_t mem [matrix_mem_pkg::FB_DEPTH];

    // write port from the decoder
    always_ff @(posedge clk_in) begin
        if (wr_req.valid) begin
            mem[wr_req.addr] <= wr_req.data;
        end
    end

    // scan side read, one cycle latency
    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/matrix_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matrix_cfg.svh"

module matrix_ctrl_top (
    input  logic                          clk_in,
    input  logic                          reset,
    input  logic                          uart_rx_line,
    input  matrix_mem_pkg::fb_addr_t      rd_addr,
    output matrix_mem_pkg::fb_data_t      rd_data,
    output logic [2:0]                    rgb_enable,
    output logic [`BRIGHTNESS_LEVELS-1:0] brightness_enable
);
    logic [7:0]                rx_byte;
    logic                      rx_valid;
    matrix_mem_pkg::fb_write_t wr_req;

    // serial line to bytes
    uart_rx uart_rx_inst (
        .clk_in       (clk_in),
        .reset        (reset),
        .uart_rx_line (uart_rx_line),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid)
    );

    command_decoder command_decoder_inst (
        .clk_in            (clk_in),
        .reset             (reset),
        .rx_byte           (rx_byte),
        .rx_valid          (rx_valid),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .wr_req            (wr_req)
    );

    // read port goes out to the scan logic
    frame_buffer frame_buffer_inst (
        .clk_in  (clk_in),
        .wr_req  (wr_req),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// ==== dv/matrix_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matrix_cfg.svh"

module matrix_ctrl_tb;

    localparam int LEVELS     = `BRIGHTNESS_LEVELS;
    localparam int BIT_CLKS   = `UART_CLKS_PER_BIT;
    localparam int ROWS       = `MATRIX_HEIGHT;
    localparam int ROW_BYTES  = `MATRIX_WIDTH * `BYTES_PER_PIXEL;
    localparam int RX_TIMEOUT = 4 * BIT_CLKS;

    localparam int MODE_IDLE = 0;
    localparam int MODE_ROW  = 1;
    localparam int MODE_DATA = 2;

    // R r G g B b
    localparam logic [7:0] CHANNEL_CMDS [6] = '{8'h52, 8'h72, 8'h47, 8'h67, 8'h42, 8'h62};
    // digits 1 to 6, then 0 and 9
    localparam logic [7:0] BRIGHT_CMDS [8] = '{8'h31, 8'h32, 8'h33, 8'h34,
                                               8'h35, 8'h36, 8'h30, 8'h39};

    logic                     clk_in = 1'b0;
    logic                     reset;
    logic                     uart_rx_line;
    matrix_mem_pkg::fb_addr_t rd_addr;
    matrix_mem_pkg::fb_data_t rd_data;
    logic [2:0]               rgb_enable;
    logic [LEVELS-1:0]        brightness_enable;

    logic [31:0]       lcg_state = 32'h35eb0bbf;
    int                rx_count = 0;
    logic [2:0]        rgb_model;
    logic [LEVELS-1:0] bright_model;
    logic [7:0]        mem_model [ROWS * ROW_BYTES];
    int                model_mode;
    int                model_row;
    int                model_col;
    int                written_rows [$];

    matrix_ctrl_top matrix_ctrl_top_inst (
        .clk_in            (clk_in),
        .reset             (reset),
        .uart_rx_line      (uart_rx_line),
        .rd_addr           (rd_addr),
        .rd_data           (rd_data),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    always #5 clk_in = ~clk_in;

    // bytes handed from the receiver to the decoder
    always @(posedge clk_in) begin
        if (matrix_ctrl_top_inst.rx_valid) begin
            rx_count <= rx_count + 1;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper lcg bits are the better ones
    function automatic int rand_below(input int n);
        return int'(next_rand() >> 8) % n;
    endfunction

    function automatic bit is_command(input logic [7:0] b);
        case (b)
            8'h52, 8'h72, 8'h47, 8'h67, 8'h42, 8'h62, 8'h4c,
            8'h30, 8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36, 8'h39: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_equal(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %0h actual %0h", test_name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch in %s", test_name);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_in);
        #1;
    endtask

    task automatic hold_line_bit(input logic value);
        uart_rx_line = value;
        repeat (BIT_CLKS) next_cycle();
    endtask

    // reference model of the command rules
    task automatic model_byte(input logic [7:0] b);
        int n;
        matrix_mem_pkg::fb_addr_t addr;
        case (model_mode)
            MODE_IDLE: begin
                n = int'(b) - 48;
                case (b)
                    8'h52: rgb_model[0] = 1'b1;
                    8'h72: rgb_model[0] = 1'b0;
                    8'h47: rgb_model[1] = 1'b1;
                    8'h67: rgb_model[1] = 1'b0;
                    8'h42: rgb_model[2] = 1'b1;
                    8'h62: rgb_model[2] = 1'b0;
                    8'h30: bright_model = '0;
                    8'h39: bright_model = '1;
                    8'h4c: model_mode = MODE_ROW;
                    // digit n flips plane LEVELS - n
                    8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36: begin
                        bright_model = bright_model ^ (LEVELS'(1) << (LEVELS - n));
                    end
                    default: begin
                    end
                endcase
            end
            MODE_ROW: begin
                if (b != 8'h4c) begin
                    model_row  = int'(b) % ROWS;
                    model_col  = 0;
                    model_mode = MODE_DATA;
                end
            end
            default: begin
                addr = matrix_mem_pkg::fb_addr_t'(model_row * ROW_BYTES + model_col);
                mem_model[addr] = b;
                model_col++;
                if (model_col == ROW_BYTES) begin
                    model_mode = MODE_IDLE;
                end
            end
        endcase
    endtask

    // one 8N1 frame, then wait for the receiver to hand the byte over
    task automatic send_byte(input string test_name, input logic [7:0] b);
        int seen;
        int waited;
        int i;
        seen = rx_count;
        hold_line_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            hold_line_bit(b[i]);
        end
        hold_line_bit(1'b1);
        waited = 0;
        while (rx_count == seen) begin
            if (waited == RX_TIMEOUT) begin
                $display("receiver delivered no byte within %0d cycles in %s",
                         RX_TIMEOUT, test_name);
                $display("SOME TESTS FAILED");
                $fatal(1, "receiver timeout");
            end
            next_cycle();
            waited++;
        end
        repeat (3) next_cycle();
        model_byte(b);
        check_equal({test_name, " rgb"}, 32'(rgb_model), 32'(rgb_enable));
        check_equal({test_name, " brightness"}, 32'(bright_model), 32'(brightness_enable));
    endtask

    task automatic send_line(input string test_name, input logic [7:0] row_byte,
                             input bit repeat_l);
        int k;
        send_byte(test_name, 8'h4c);
        if (repeat_l) begin
            send_byte({test_name, " skipped L"}, 8'h4c);
        end
        send_byte({test_name, " row"}, row_byte);
        for (k = 0; k < ROW_BYTES; k++) begin
            send_byte({test_name, " data"}, 8'(next_rand() >> 16));
        end
        written_rows.push_back(int'(row_byte) % ROWS);
    endtask

    task automatic check_row(input string test_name, input int row);
        int k;
        matrix_mem_pkg::fb_addr_t addr;
        for (k = 0; k < ROW_BYTES; k++) begin
            addr = matrix_mem_pkg::fb_addr_t'(row * ROW_BYTES + k);
            rd_addr = addr;
            next_cycle();
            check_equal($sformatf("%s row %0d byte %0d", test_name, row, k),
                        32'(mem_model[addr]), 32'(rd_data));
        end
    endtask

    task automatic send_unknown(input string test_name);
        logic [7:0] b;
        b = 8'(next_rand() >> 16);
        while (is_command(b)) begin
            b = b + 8'd1;
        end
        send_byte(test_name, b);
    endtask

    initial begin
        int i;
        int seg;
        int sel;
        int row_a;
        int row_b;
        reset        = 1'b1;
        uart_rx_line = 1'b1;
        rd_addr      = '0;
        rgb_model    = '1;
        bright_model = '1;
        model_mode   = MODE_IDLE;
        model_row    = 0;
        model_col    = 0;
        repeat (5) next_cycle();
        reset = 1'b0;
        next_cycle();

        check_equal("reset rgb", 32'h7, 32'(rgb_enable));
        check_equal("reset brightness", (32'd1 << LEVELS) - 32'd1, 32'(brightness_enable));

        for (i = 0; i < 24; i++) begin
            sel = rand_below(6);
            send_byte("channel", CHANNEL_CMDS[3'(sel)]);
        end

        // clear, set, every single toggle, then random digits
        send_byte("brightness clear", 8'h30);
        send_byte("brightness set", 8'h39);
        for (i = 1; i <= LEVELS; i++) begin
            send_byte("brightness toggle", 8'h30 + 8'(i));
        end
        for (i = 0; i < 30; i++) begin
            sel = rand_below(8);
            send_byte("brightness", BRIGHT_CMDS[3'(sel)]);
        end

        row_a = rand_below(ROWS);
        send_line("line", 8'(row_a), 1'b0);
        check_row("line readback", row_a);

        for (i = 0; i < 10; i++) begin
            send_unknown("unknown");
        end
        // upper bits of the row byte are don't care
        row_b = (row_a + 1 + rand_below(ROWS - 1)) % ROWS;
        send_line("second line", 8'he0 | 8'(row_b), 1'b1);
        check_row("first row kept", row_a);
        check_row("second row", row_b);

        for (seg = 0; seg < 3; seg++) begin
            for (i = 0; i < 12; i++) begin
                sel = rand_below(3);
                if (sel == 0) begin
                    send_byte("mixed channel", CHANNEL_CMDS[3'(rand_below(6))]);
                end else if (sel == 1) begin
                    send_byte("mixed brightness", BRIGHT_CMDS[3'(rand_below(8))]);
                end else begin
                    send_unknown("mixed unknown");
                end
            end
            if (seg < 2) begin
                send_line("mixed line", 8'(rand_below(ROWS)), 1'b0);
            end
        end
        for (i = 0; i < written_rows.size(); i++) begin
            check_row("mixed readback", written_rows[i]);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/matrix_cmd_pkg.sv
verilog/matrix_mem_pkg.sv
verilog/uart_rx.sv
verilog/command_decoder.sv
verilog/frame_buffer.sv
verilog/matrix_ctrl_top.sv
dv/matrix_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run of the matrix command front end testbench

TOP := matrix_ctrl_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
